/* hdl/fused_pkg.sv */
package fused_pkg;

    localparam int LANES     = 16;
    localparam int NUM_L1    = LANES;   // One activation vector fills one word
    localparam int NUM_L2    = 4;
    localparam int ACC_W     = 32;
    localparam int RELU6_MAX = 96;      // 6.0 with four fraction bits

    typedef logic signed [7:0] lane_t;

    typedef lane_t [LANES-1:0] vec_t;   // 128-bit memory word

    typedef enum logic [1:0] {
        SEL_IFM,
        SEL_W1,
        SEL_W2
    } mem_sel_e;

    typedef struct packed {
        logic       we;
        mem_sel_e   sel;
        logic [15:0] addr;
        vec_t       data;
    } load_cmd_t;

    // Layer-1 strobes, aligned with memory read data
    typedef struct packed {
        logic clear;
        logic acc_en;
        logic window_done;
    } l1_ctl_t;

    typedef struct packed {
        logic                     valid;
        logic [15:0]              addr;
        lane_t [NUM_L2-1:0]       data;
    } result_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } seq_state_e;

endpackage

/* hdl/operand_memories.sv */
`timescale 1ns/10ps

module operand_memories #(
    parameter int WINDOW  = 9,
    parameter int NUM_PIX = 8
) (
    input  logic                                    clk,
    input  fused_pkg::load_cmd_t                    load,
    input  logic                                    busy,
    input  logic [15:0]                             rd_addr_ifm,
    input  logic [15:0]                             rd_tap,
    output fused_pkg::vec_t                         ifm_word,
    output fused_pkg::vec_t [fused_pkg::NUM_L1-1:0] w1_words,
    output fused_pkg::vec_t [fused_pkg::NUM_L2-1:0] w2_words
);

    localparam int IFM_DEPTH = NUM_PIX * WINDOW;
    localparam int IFM_AW    = (IFM_DEPTH > 1) ? $clog2(IFM_DEPTH) : 1;
    localparam int TAP_AW    = (WINDOW > 1) ? $clog2(WINDOW) : 1;
    localparam int W2_AW     = (fused_pkg::NUM_L2 > 1) ? $clog2(fused_pkg::NUM_L2) : 1;

    fused_pkg::vec_t ifm_mem [IFM_DEPTH];
    fused_pkg::vec_t w2_mem  [fused_pkg::NUM_L2];
    logic            wr_ok;

    assign wr_ok = load.we && !busy;    // Load port is closed during a run

    // Input map, one pre-arranged window per pixel
    always_ff @(posedge clk) begin
        if (wr_ok && load.sel == fused_pkg::SEL_IFM && load.addr < 16'(IFM_DEPTH)) begin
            ifm_mem[load.addr[IFM_AW-1:0]] <= load.data;
        end
        ifm_word <= ifm_mem[rd_addr_ifm[IFM_AW-1:0]];
    end

    // One bank per layer-1 filter, all read at the same tap
    for (genvar f = 0; f < fused_pkg::NUM_L1; f++) begin : g_w1_bank
        fused_pkg::vec_t bank [WINDOW];
        fused_pkg::vec_t rd_word;
        logic [15:0]     wr_tap;
        logic            hit;

        assign wr_tap = load.addr - 16'(f * WINDOW);
        assign hit    = wr_ok && load.sel == fused_pkg::SEL_W1 &&
                        load.addr >= 16'(f * WINDOW) && load.addr < 16'((f + 1) * WINDOW);

        always_ff @(posedge clk) begin
            if (hit) begin
                bank[wr_tap[TAP_AW-1:0]] <= load.data;
            end
            rd_word <= bank[rd_tap[TAP_AW-1:0]];
        end

        assign w1_words[f] = rd_word;
    end

    // Layer-2 weights, a single word per filter
    always_ff @(posedge clk) begin
        if (wr_ok && load.sel == fused_pkg::SEL_W2 && load.addr < 16'(fused_pkg::NUM_L2)) begin
            w2_mem[load.addr[W2_AW-1:0]] <= load.data;
        end
    end

    always_comb begin
        for (int j = 0; j < fused_pkg::NUM_L2; j++) begin
            w2_words[j] = w2_mem[j];    // Read continuously
        end
    end

endmodule

/* hdl/window_sequencer.sv */
`timescale 1ns/10ps

module window_sequencer #(
    parameter int WINDOW  = 9,
    parameter int NUM_PIX = 8
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               start,
    output logic [15:0]        rd_addr_ifm,
    output logic [15:0]        rd_tap,
    output fused_pkg::l1_ctl_t l1_ctl,
    output logic               busy,
    output logic               done
);

    // Memory read, cluster register and two pointwise registers
    localparam int DRAIN_CYC = 4;

    fused_pkg::seq_state_e state;
    logic [15:0]           pix_cnt;
    logic [15:0]           tap_cnt;
    logic [15:0]           word_cnt;
    logic [2:0]            drain_cnt;
    fused_pkg::l1_ctl_t    ctl_next;
    logic                  last_tap;

    assign last_tap = (tap_cnt == 16'(WINDOW - 1));

    // Strobes for the tap being addressed this cycle
    always_comb begin
        ctl_next.clear       = (state == fused_pkg::RUN) && (tap_cnt == 16'd0);
        ctl_next.acc_en      = (state == fused_pkg::RUN);
        ctl_next.window_done = (state == fused_pkg::RUN) && last_tap;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= fused_pkg::IDLE;
            pix_cnt   <= '0;
            tap_cnt   <= '0;
            word_cnt  <= '0;
            drain_cnt <= '0;
            l1_ctl    <= '0;
            done      <= 1'b0;
        end else begin
            l1_ctl <= ctl_next;     // Lines up with read data
            done   <= 1'b0;
            case (state)
                fused_pkg::IDLE: begin
                    if (start) begin
                        state    <= fused_pkg::RUN;
                        pix_cnt  <= '0;
                        tap_cnt  <= '0;
                        word_cnt <= '0;
                    end
                end
                fused_pkg::RUN: begin
                    if (last_tap) begin
                        tap_cnt <= '0;
                        if (pix_cnt == 16'(NUM_PIX - 1)) begin
                            state     <= fused_pkg::DRAIN;
                            pix_cnt   <= '0;
                            word_cnt  <= '0;
                            drain_cnt <= '0;
                        end else begin
                            pix_cnt  <= pix_cnt + 16'd1;   // Next pixel back to back
                            word_cnt <= word_cnt + 16'd1;
                        end
                    end else begin
                        tap_cnt  <= tap_cnt + 16'd1;
                        word_cnt <= word_cnt + 16'd1;
                    end
                end
                fused_pkg::DRAIN: begin
                    if (drain_cnt == 3'(DRAIN_CYC - 1)) begin
                        state <= fused_pkg::IDLE;
                        done  <= 1'b1;  // Cycle after the last result
                    end else begin
                        drain_cnt <= drain_cnt + 3'd1;
                    end
                end
                default: state <= fused_pkg::IDLE;
            endcase
        end
    end

    assign rd_addr_ifm = word_cnt;
    assign rd_tap      = tap_cnt;
    assign busy        = (state != fused_pkg::IDLE);

endmodule

/* hdl/conv_pe_cluster.sv */
`timescale 1ns/10ps

module conv_pe_cluster #(
    parameter int L1_SHIFT = 4
) (
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  fused_pkg::l1_ctl_t                      l1_ctl,
    input  fused_pkg::vec_t                         ifm_word,
    input  fused_pkg::vec_t [fused_pkg::NUM_L1-1:0] w1_words,
    output fused_pkg::vec_t                         act_vec,
    output logic                                    act_valid
);

    typedef logic signed [fused_pkg::ACC_W-1:0] acc_t;

    logic signed [fused_pkg::ACC_W-1:0] acc      [fused_pkg::NUM_L1];
    logic signed [fused_pkg::ACC_W-1:0] prod_sum [fused_pkg::NUM_L1];
    logic signed [fused_pkg::ACC_W-1:0] total    [fused_pkg::NUM_L1];

    // Requantize then ReLU6
    function automatic fused_pkg::lane_t relu6(input logic signed [fused_pkg::ACC_W-1:0] v);
        logic signed [fused_pkg::ACC_W-1:0] s;
        s = v >>> L1_SHIFT;
        if (s < 0) begin
            return '0;
        end else if (s > fused_pkg::RELU6_MAX) begin
            return fused_pkg::lane_t'(fused_pkg::RELU6_MAX);
        end
        return fused_pkg::lane_t'(s);
    endfunction

    always_comb begin
        for (int f = 0; f < fused_pkg::NUM_L1; f++) begin
            prod_sum[f] = '0;
            for (int l = 0; l < fused_pkg::LANES; l++) begin
                prod_sum[f] += acc_t'($signed(ifm_word[l])) *
                               acc_t'($signed(w1_words[f][l]));
            end
            total[f] = (l1_ctl.clear ? '0 : acc[f]) + prod_sum[f];   // First tap restarts
        end
    end

    always_ff @(posedge clk) begin
        for (int f = 0; f < fused_pkg::NUM_L1; f++) begin
            if (l1_ctl.acc_en) begin
                acc[f] <= total[f];
            end
            if (l1_ctl.window_done) begin
                act_vec[f] <= relu6(total[f]);  // Includes the last product
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            act_valid <= 1'b0;
        end else begin
            act_valid <= l1_ctl.window_done;
        end
    end

endmodule

/* hdl/pointwise_stage.sv */
`timescale 1ns/10ps

module pointwise_stage #(
    parameter int NUM_PIX  = 8,
    parameter int L2_SHIFT = 4
) (
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  fused_pkg::vec_t                         act_vec,
    input  logic                                    act_valid,
    input  fused_pkg::vec_t [fused_pkg::NUM_L2-1:0] w2_words,
    output fused_pkg::result_t                      result
);

    typedef logic signed [fused_pkg::ACC_W-1:0] acc_t;

    fused_pkg::vec_t                         act_q;
    logic                                    act_q_valid;
    logic signed [fused_pkg::ACC_W-1:0]      dot [fused_pkg::NUM_L2];
    fused_pkg::lane_t [fused_pkg::NUM_L2-1:0] sat_bytes;
    fused_pkg::lane_t [fused_pkg::NUM_L2-1:0] res_data;
    logic                                    res_valid;
    logic [15:0]                             res_addr;
    logic [15:0]                             addr_cnt;

    // Requantize and saturate to int8
    function automatic fused_pkg::lane_t sat8(input logic signed [fused_pkg::ACC_W-1:0] v);
        logic signed [fused_pkg::ACC_W-1:0] s;
        s = v >>> L2_SHIFT;
        if (s > 127) begin
            return fused_pkg::lane_t'(127);
        end else if (s < -128) begin
            return fused_pkg::lane_t'(-128);
        end
        return fused_pkg::lane_t'(s);
    endfunction

    // Stage one frees layer 1 for the next pixel
    always_ff @(posedge clk) begin
        if (act_valid) begin
            act_q <= act_vec;
        end
    end

    always_comb begin
        for (int j = 0; j < fused_pkg::NUM_L2; j++) begin
            dot[j] = '0;
            for (int l = 0; l < fused_pkg::LANES; l++) begin
                dot[j] += acc_t'($signed(act_q[l])) * acc_t'($signed(w2_words[j][l]));
            end
            sat_bytes[j] = sat8(dot[j]);
        end
    end

    // Stage two, output word with its pixel number
    always_ff @(posedge clk) begin
        if (act_q_valid) begin
            res_data <= sat_bytes;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            act_q_valid <= 1'b0;
            res_valid   <= 1'b0;
            res_addr    <= '0;
            addr_cnt    <= '0;
        end else begin
            act_q_valid <= act_valid;
            res_valid   <= act_q_valid;
            if (act_q_valid) begin
                res_addr <= addr_cnt;
                if (addr_cnt == 16'(NUM_PIX - 1)) begin
                    addr_cnt <= '0;     // Ready for the next run
                end else begin
                    addr_cnt <= addr_cnt + 16'd1;
                end
            end
        end
    end

    assign result.valid = res_valid;
    assign result.addr  = res_addr;
    assign result.data  = res_data;

endmodule

/* hdl/fused_top.sv */
`timescale 1ns/10ps

module fused_top #(
    parameter int WINDOW   = 9,
    parameter int NUM_PIX  = 8,
    parameter int L1_SHIFT = 4,
    parameter int L2_SHIFT = 4
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 start,
    input  fused_pkg::load_cmd_t load,
    output logic                 busy,
    output logic                 done,
    output fused_pkg::result_t   result
);

    logic [15:0]                             rd_addr_ifm;
    logic [15:0]                             rd_tap;
    fused_pkg::l1_ctl_t                      l1_ctl;
    fused_pkg::vec_t                         ifm_word;
    fused_pkg::vec_t [fused_pkg::NUM_L1-1:0] w1_words;
    fused_pkg::vec_t [fused_pkg::NUM_L2-1:0] w2_words;
    fused_pkg::vec_t                         act_vec;
    logic                                    act_valid;

    operand_memories #(
        .WINDOW  (WINDOW),
        .NUM_PIX (NUM_PIX)
    ) mem_i (
        .clk         (clk),
        .load        (load),
        .busy        (busy),
        .rd_addr_ifm (rd_addr_ifm),
        .rd_tap      (rd_tap),
        .ifm_word    (ifm_word),
        .w1_words    (w1_words),
        .w2_words    (w2_words)
    );

    window_sequencer #(
        .WINDOW  (WINDOW),
        .NUM_PIX (NUM_PIX)
    ) seq_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .start       (start),
        .rd_addr_ifm (rd_addr_ifm),
        .rd_tap      (rd_tap),
        .l1_ctl      (l1_ctl),
        .busy        (busy),
        .done        (done)
    );

    conv_pe_cluster #(
        .L1_SHIFT (L1_SHIFT)
    ) l1_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .l1_ctl    (l1_ctl),
        .ifm_word  (ifm_word),
        .w1_words  (w1_words),
        .act_vec   (act_vec),
        .act_valid (act_valid)
    );

    pointwise_stage #(
        .NUM_PIX  (NUM_PIX),
        .L2_SHIFT (L2_SHIFT)
    ) l2_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .act_vec   (act_vec),
        .act_valid (act_valid),
        .w2_words  (w2_words),
        .result    (result)
    );

endmodule

/* bench/fused_assertions.sv */
`timescale 1ns/10ps

module fused_assertions #(
    parameter int WINDOW  = 9,
    parameter int NUM_PIX = 8
) (
    input logic               clk,
    input logic               reset_n,
    input logic               start,
    input logic               busy,
    input logic               done,
    input fused_pkg::result_t result
);

    localparam logic [15:0] LAST_PIX = 16'(NUM_PIX - 1);

    int          fail_cnt = 0;
    logic [15:0] next_addr;     // Address the next result must carry
    logic [15:0] run_cycle;     // Cycles since the accepted start

    task automatic raise_failure(input string what);
        fail_cnt++;
        $error("%s", what);
    endtask

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            next_addr <= '0;
            run_cycle <= '0;
        end else begin
            if (start && !busy) begin
                run_cycle <= 16'd1;
            end else if (busy) begin
                run_cycle <= run_cycle + 16'd1;
            end
            if (result.valid) begin
                next_addr <= (result.addr == LAST_PIX) ? '0 : result.addr + 16'd1;
            end
        end
    end

    quiet_after_reset: assert property (@(posedge clk)
        !reset_n |=> !busy && !done && !result.valid)
        else raise_failure("busy, done or result active right after reset");

    idle_until_start: assert property (@(posedge clk) disable iff (!reset_n)
        !busy && !start |=> !busy)
        else raise_failure("busy rose without a start pulse");

    result_in_run: assert property (@(posedge clk) disable iff (!reset_n)
        result.valid |-> busy)
        else raise_failure("result strobe outside a run");

    addr_in_order: assert property (@(posedge clk) disable iff (!reset_n)
        result.valid |-> result.addr == next_addr)
        else raise_failure("result address out of order");

    // Exactly one done, right behind the last pixel
    done_after_last: assert property (@(posedge clk) disable iff (!reset_n)
        done == $past(result.valid && result.addr == LAST_PIX))
        else raise_failure("done not one cycle after the last result");

    result_latency: assert property (@(posedge clk) disable iff (!reset_n)
        result.valid |-> run_cycle == 16'(WINDOW * (int'(result.addr) + 1) + 4))
        else raise_failure("result outside its time slot after start");

endmodule

bind fused_top fused_assertions #(
    .WINDOW  (WINDOW),
    .NUM_PIX (NUM_PIX)
) protocol_chk (
    .clk     (clk),
    .reset_n (reset_n),
    .start   (start),
    .busy    (busy),
    .done    (done),
    .result  (result)
);

/* bench/fused_tb.sv */
`timescale 1ns/10ps

module fused_tb;

    localparam int WINDOW      = 9;
    localparam int NUM_PIX     = 8;
    localparam int L1_SHIFT    = 4;
    localparam int L2_SHIFT    = 4;
    localparam int PIX_AW      = $clog2(NUM_PIX);
    localparam int TESTS       = 6;
    localparam int LOAD_LEN    = (NUM_PIX + fused_pkg::NUM_L1) * WINDOW + fused_pkg::NUM_L2;
    localparam int LIMIT       = TESTS * (LOAD_LEN + (NUM_PIX + 1) * WINDOW) + 200;
    localparam int MODE_RANDOM = 0;
    localparam int MODE_CLAMP  = 1;
    localparam int MODE_SAT    = 2;    // Layer-2 weights only

    logic                 clk = 1'b0;
    logic                 reset_n;
    logic                 start;
    fused_pkg::load_cmd_t load;
    logic                 busy;
    logic                 done;
    fused_pkg::result_t   result;

    fused_pkg::vec_t ifm_m [NUM_PIX * WINDOW];   // What the DUT should hold
    fused_pkg::vec_t w1_m  [fused_pkg::NUM_L1 * WINDOW];
    fused_pkg::vec_t w2_m  [fused_pkg::NUM_L2];
    fused_pkg::lane_t [fused_pkg::NUM_L2-1:0] exp_data [NUM_PIX];
    int errors      = 0;
    int checks      = 0;
    int counted     = 0;
    int last_errors = 0;

    fused_top #(
        .WINDOW   (WINDOW),
        .NUM_PIX  (NUM_PIX),
        .L1_SHIFT (L1_SHIFT),
        .L2_SHIFT (L2_SHIFT)
    ) dut_i (
        .clk     (clk),
        .reset_n (reset_n),
        .start   (start),
        .load    (load),
        .busy    (busy),
        .done    (done),
        .result  (result)
    );

    always #5 clk = ~clk;

    function automatic fused_pkg::vec_t make_word(input int mode, input fused_pkg::mem_sel_e sel,
                                                  input int idx);
        fused_pkg::vec_t w;
        for (int l = 0; l < fused_pkg::LANES; l++) begin
            if (mode == MODE_RANDOM) begin
                w[l] = fused_pkg::lane_t'($urandom);
            end else if (sel == fused_pkg::SEL_IFM) begin
                w[l] = 8'sd8;
            end else if (sel == fused_pkg::SEL_W1) begin
                case ((idx / WINDOW) % 3)       // Filter picks a high, negative or mid sum
                    0:       w[l] = 8'sd16;
                    1:       w[l] = -8'sd16;
                    default: w[l] = 8'sd1;
                endcase
            end else if (mode == MODE_CLAMP) begin
                w[l] = (l == idx) ? 8'sd16 : 8'sd0;    // Passes activation idx through
            end else begin
                w[l] = idx[0] ? fused_pkg::lane_t'(-128) : 8'sd127;
            end
        end
        return w;
    endfunction

    function automatic int error_total();
        return errors + dut_i.protocol_chk.fail_cnt;
    endfunction

    task automatic write_word(input fused_pkg::mem_sel_e sel, input int addr,
                              input fused_pkg::vec_t data, input bit track);
        @(posedge clk);
        load.we   <= 1'b1;
        load.sel  <= sel;
        load.addr <= 16'(addr);
        load.data <= data;
        if (track) begin
            case (sel)
                fused_pkg::SEL_IFM: ifm_m[addr] = data;
                fused_pkg::SEL_W1:  w1_m[addr] = data;
                default:            w2_m[addr] = data;
            endcase
        end
    endtask

    task automatic load_operands(input int mode);
        if (mode != MODE_SAT) begin
            for (int i = 0; i < NUM_PIX * WINDOW; i++) begin
                write_word(fused_pkg::SEL_IFM, i, make_word(mode, fused_pkg::SEL_IFM, i), 1'b1);
            end
            for (int i = 0; i < fused_pkg::NUM_L1 * WINDOW; i++) begin
                write_word(fused_pkg::SEL_W1, i, make_word(mode, fused_pkg::SEL_W1, i), 1'b1);
            end
        end
        for (int j = 0; j < fused_pkg::NUM_L2; j++) begin
            write_word(fused_pkg::SEL_W2, j, make_word(mode, fused_pkg::SEL_W2, j), 1'b1);
        end
        @(posedge clk);
        load.we <= 1'b0;
    endtask

    // Window sums, ReLU6, then the 1x1 layer with int8 saturation
    task automatic compute_expected();
        int acc;
        int act [fused_pkg::NUM_L1];
        for (int p = 0; p < NUM_PIX; p++) begin
            for (int f = 0; f < fused_pkg::NUM_L1; f++) begin
                acc = 0;
                for (int k = 0; k < WINDOW; k++) begin
                    for (int l = 0; l < fused_pkg::LANES; l++) begin
                        acc += int'(ifm_m[p * WINDOW + k][l]) * int'(w1_m[f * WINDOW + k][l]);
                    end
                end
                acc    = acc >>> L1_SHIFT;
                act[f] = (acc < 0) ? 0 : ((acc > fused_pkg::RELU6_MAX) ? fused_pkg::RELU6_MAX : acc);
            end
            for (int j = 0; j < fused_pkg::NUM_L2; j++) begin
                acc = 0;
                for (int l = 0; l < fused_pkg::LANES; l++) begin
                    acc += act[l] * int'(w2_m[j][l]);
                end
                acc            = acc >>> L2_SHIFT;
                acc            = (acc > 127) ? 127 : ((acc < -128) ? -128 : acc);
                exp_data[p][j] = fused_pkg::lane_t'(acc);
            end
        end
    endtask

    // Results seen since the last call must number exactly want
    task automatic count_results(input int want);
        if (checks - counted != want) begin
            errors++;
            $display("wrong number of results at %0t: %0d seen where %0d were expected",
                     $time, checks - counted, want);
        end
        counted = checks;
    endtask

    task automatic run_once(input bit disturb);
        compute_expected();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (disturb) begin
            for (int i = 0; i < 20; i++) begin
                write_word(fused_pkg::mem_sel_e'($urandom_range(2)), int'($urandom_range(3)),
                           make_word(MODE_RANDOM, fused_pkg::SEL_IFM, 0), 1'b0);
                start <= (i == 5);     // Second start in the middle of the run
            end
            @(posedge clk);
            start   <= 1'b0;
            load.we <= 1'b0;
        end
        do @(negedge clk); while (!done);
        count_results(NUM_PIX);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        errors++;
        $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, want);
    endtask

    task automatic finish_test(input int num, input string name);
        int now_errors;
        now_errors = error_total();
        $display("test %0d %s: %0d errors", num, name, now_errors - last_errors);
        last_errors = now_errors;
    endtask

    always @(negedge clk) begin
        if (result.valid) begin
            checks++;
        end
    end

    data_check: assert property (@(posedge clk) disable iff (!reset_n)
        result.valid |-> result.data == exp_data[result.addr[PIX_AW-1:0]])
        else report_mismatch("result.data", $sampled(result.data),
                             exp_data[$sampled(result.addr[PIX_AW-1:0])]);

    // Every run yields NUM_PIX words numbered from zero, the current one already counted
    addr_check: assert property (@(posedge clk) disable iff (!reset_n)
        result.valid |-> result.addr == 16'((checks - 1) % NUM_PIX))
        else report_mismatch("result.addr", 32'($sampled(result.addr)),
                             (checks - 1) % NUM_PIX);

    initial begin
        void'($urandom(32'h203e_00db));
        reset_n = 1'b0;
        start   = 1'b0;
        load    = '0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        repeat (4) @(posedge clk);
        count_results(0);
        finish_test(1, "quiet after reset");
        load_operands(MODE_RANDOM);
        run_once(1'b0);
        finish_test(2, "random run");
        load_operands(MODE_CLAMP);
        run_once(1'b0);
        finish_test(3, "activation clamp");
        load_operands(MODE_SAT);
        run_once(1'b0);
        finish_test(4, "saturation");
        run_once(1'b0);
        finish_test(5, "timing");
        load_operands(MODE_RANDOM);
        run_once(1'b1);
        repeat (20) @(posedge clk);    // Idle gap where a stray burst would show
        count_results(0);
        run_once(1'b0);
        finish_test(6, "start and load while busy");
        repeat (2) @(posedge clk);
        $display("tests %0d, results checked %0d, errors %0d", TESTS, checks, error_total());
        if (error_total() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", LIMIT);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* fused_top.f */
hdl/fused_pkg.sv
hdl/operand_memories.sv
hdl/window_sequencer.sv
hdl/conv_pe_cluster.sv
hdl/pointwise_stage.sv
hdl/fused_top.sv
bench/fused_assertions.sv
bench/fused_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module fused_tb -f fused_top.f
./obj_dir/Vfused_tb +verilator+error+limit+100 | tee /dev/stderr \
    | grep -cx 'ALL CHECKS PASSED' > /dev/null
